// ==== Makefile ====
# Verilator build and run for the word-copy DMA testbench
VERILATOR ?= verilator
TOP       ?= tb_dma_top
FILELIST  ?= dma_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dma_copy_backend.sv ====
// word copier doing one read at src and then one write at dst per word
// takes a descriptor only when idle and pulses done_o at the end
module dma_copy_backend
  import dma_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  dma_xfer_if.sink xfer,
  output logic     mem_req_o,
  output logic     mem_we_o,
  output addr_t    mem_addr_o,
  output data_t    mem_wdata_o,
  input  logic     mem_gnt_i,
  input  logic     mem_rvalid_i,
  input  data_t    mem_rdata_i,
  output logic     done_o,
  output logic     busy_o
);

  copy_state_e state_q;
  addr_t       src_q;
  addr_t       dst_q;
  len_t        remaining_q;
  data_t       word_q;
  logic        done_q;
  logic        accept;

  // next descriptor waits out the done pulse
  assign xfer.ready = (state_q == st_idle) && !done_q;
  assign accept     = xfer.valid && xfer.ready;

  // --------------------
  // memory port
  assign mem_req_o   = (state_q == st_read_req) || (state_q == st_write_req);
  assign mem_we_o    = (state_q == st_write_req);
  assign mem_addr_o  = (state_q == st_write_req) ? dst_q : src_q;
  assign mem_wdata_o = word_q;

  assign done_o = done_q;
  assign busy_o = (state_q != st_idle);

  // --------------------
  // copy FSM
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= st_idle;
      src_q       <= '0;
      dst_q       <= '0;
      remaining_q <= '0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (accept) begin
            src_q       <= xfer.src;
            dst_q       <= xfer.dst;
            remaining_q <= xfer.len;
            // nothing to move so finish right away
            if (xfer.len == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= st_read_req;
            end
          end
        end
        st_read_req: begin
          if (mem_gnt_i) begin
            state_q <= st_read_wait;
          end
        end
        st_read_wait: begin
          if (mem_rvalid_i) begin
            state_q <= st_write_req;
          end
        end
        st_write_req: begin
          if (mem_gnt_i) begin
            src_q       <= src_q + addr_t'(1);
            dst_q       <= dst_q + addr_t'(1);
            remaining_q <= remaining_q - len_t'(1);
            if (remaining_q == len_t'(1)) begin
              done_q  <= 1'b1;
              state_q <= st_idle;
            end else begin
              state_q <= st_read_req;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // read word held for the following write
  always_ff @(posedge clk_i) begin
    if ((state_q == st_read_wait) && mem_rvalid_i) begin
      word_q <= mem_rdata_i;
    end
  end

endmodule

// ==== dma_pkg.sv ====
// shared widths, register map and state encoding for the word-copy DMA
// every design file imports this package in its module header
package dma_pkg;

  // --------------------
  // word and field widths
  typedef logic [31:0] data_t;
  typedef logic [15:0] addr_t;
  typedef logic [15:0] len_t;
  typedef logic [31:0] xfer_id_t;
  typedef logic [2:0]  reg_addr_t;

  // --------------------
  // register map on the config port
  localparam reg_addr_t RegSrc    = 3'd0;
  localparam reg_addr_t RegDst    = 3'd1;
  localparam reg_addr_t RegLen    = 3'd2;
  // read only from here on
  localparam reg_addr_t RegLaunch = 3'd3;
  localparam reg_addr_t RegDoneId = 3'd4;
  localparam reg_addr_t RegStatus = 3'd5;

  // descriptor slots between frontend and backend
  localparam int unsigned QueueDepth = 2;

  // --------------------
  // backend copy FSM
  typedef enum logic [1:0] {
    st_idle       = 2'd0,
    st_read_req   = 2'd1,
    st_read_wait  = 2'd2,
    st_write_req  = 2'd3
  } copy_state_e;

endpackage

// ==== dma_reg_frontend.sv ====
// config register port of the DMA: holds the transfer fields, launches on a
// read of the launch register and tracks next and done transfer IDs
module dma_reg_frontend
  import dma_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cfg_req_i,
  input  logic       cfg_we_i,
  input  reg_addr_t  cfg_addr_i,
  input  data_t      cfg_wdata_i,
  output logic       cfg_gnt_o,
  output logic       cfg_rvalid_o,
  output data_t      cfg_rdata_o,
  dma_xfer_if.source xfer,
  input  logic       done_i,
  input  logic       backend_busy_i,
  output logic       busy_o,
  output logic       term_event_o
);

  addr_t    src_q;
  addr_t    dst_q;
  len_t     len_q;
  xfer_id_t next_id_q;
  xfer_id_t done_id_q;
  xfer_id_t last_id;
  logic     launch_req;
  logic     launch_fire;
  logic     rvalid_q;
  logic     term_event_q;
  data_t    rdata_d;
  data_t    rdata_q;

  // --------------------
  // grant and launch
  assign launch_req  = cfg_req_i && !cfg_we_i && (cfg_addr_i == RegLaunch);
  // launch waits for a free queue slot, everything else goes through
  assign cfg_gnt_o   = cfg_req_i && (!launch_req || xfer.ready);
  assign launch_fire = launch_req && xfer.ready;

  assign xfer.valid = launch_req;
  assign xfer.src   = src_q;
  assign xfer.dst   = dst_q;
  assign xfer.len   = len_q;

  assign last_id = next_id_q - xfer_id_t'(1);
  assign busy_o  = (done_id_q != last_id) || backend_busy_i;

  always_comb begin
    case (cfg_addr_i)
      RegSrc:    rdata_d = data_t'(src_q);
      RegDst:    rdata_d = data_t'(dst_q);
      RegLen:    rdata_d = data_t'(len_q);
      RegLaunch: rdata_d = next_id_q;
      RegDoneId: rdata_d = done_id_q;
      RegStatus: rdata_d = {{($bits(data_t) - 1){1'b0}}, busy_o};
      default:   rdata_d = '0;
    endcase
  end

  // --------------------
  // registers and counters
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      next_id_q    <= xfer_id_t'(1);
      done_id_q    <= '0;
      rvalid_q     <= 1'b0;
      term_event_q <= 1'b0;
    end else begin
      rvalid_q     <= cfg_gnt_o;
      term_event_q <= done_i;
      if (cfg_gnt_o && cfg_we_i) begin
        case (cfg_addr_i)
          RegSrc:  src_q <= addr_t'(cfg_wdata_i);
          RegDst:  dst_q <= addr_t'(cfg_wdata_i);
          RegLen:  len_q <= len_t'(cfg_wdata_i);
          default: ;
        endcase
      end
      if (launch_fire) begin
        next_id_q <= next_id_q + xfer_id_t'(1);
      end
      if (done_i) begin
        done_id_q <= done_id_q + xfer_id_t'(1);
      end
    end
  end

  // read data for the response cycle, zero for writes
  always_ff @(posedge clk_i) begin
    if (cfg_gnt_o) begin
      rdata_q <= cfg_we_i ? '0 : rdata_d;
    end
  end

  assign cfg_rvalid_o = rvalid_q;
  assign cfg_rdata_o  = rdata_q;
  assign term_event_o = term_event_q;

endmodule

// ==== dma_stim.txt ====
# one transfer per line, hex: src dst len expected_id
# words src..src+len-1 are copied to dst..dst+len-1
0100 2000 0010 1
0200 2100 0004 2
0300 2200 0000 3
0400 2300 0006 4
0500 2400 0003 5
0600 2500 0000 6
0700 2600 0001 7

// ==== dma_top.f ====
dma_pkg.sv
dma_xfer_if.sv
dma_reg_frontend.sv
dma_xfer_queue.sv
dma_copy_backend.sv
dma_top.sv
tb_dma_properties.sv
tb_dma_top.sv

// ==== dma_top.sv ====
// top level of the one-channel word-copy DMA
// config port in, memory port out, frontend -> queue -> backend
module dma_top
  import dma_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  // config port
  input  logic      cfg_req_i,
  input  logic      cfg_we_i,
  input  reg_addr_t cfg_addr_i,
  input  data_t     cfg_wdata_i,
  output logic      cfg_gnt_o,
  output logic      cfg_rvalid_o,
  output data_t     cfg_rdata_o,
  // memory port
  output logic      mem_req_o,
  output logic      mem_we_o,
  output addr_t     mem_addr_o,
  output data_t     mem_wdata_o,
  input  logic      mem_gnt_i,
  input  logic      mem_rvalid_i,
  input  data_t     mem_rdata_i,
  // status
  output logic      term_event_o,
  output logic      busy_o
);

  logic backend_done;
  logic backend_busy;

  dma_xfer_if fe_xfer ();
  dma_xfer_if be_xfer ();

  dma_reg_frontend dma_reg_frontend_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cfg_req_i      (cfg_req_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_gnt_o      (cfg_gnt_o),
    .cfg_rvalid_o   (cfg_rvalid_o),
    .cfg_rdata_o    (cfg_rdata_o),
    .xfer           (fe_xfer.source),
    .done_i         (backend_done),
    .backend_busy_i (backend_busy),
    .busy_o         (busy_o),
    .term_event_o   (term_event_o)
  );

  dma_xfer_queue dma_xfer_queue_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in      (fe_xfer.sink),
    .out     (be_xfer.source)
  );

  dma_copy_backend dma_copy_backend_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .xfer         (be_xfer.sink),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .done_o       (backend_done),
    .busy_o       (backend_busy)
  );

endmodule

// ==== dma_xfer_if.sv ====
// valid/ready channel for one transfer descriptor inside the DMA
// frontend to queue and queue to backend both use it
interface dma_xfer_if
  import dma_pkg::*;
();

  addr_t src;
  addr_t dst;
  len_t  len;
  logic  valid;
  logic  ready;

  // producer of descriptors
  modport source (
    output src, dst, len, valid,
    input  ready
  );

  // consumer of descriptors
  modport sink (
    input  src, dst, len, valid,
    output ready
  );

endinterface

// ==== dma_xfer_queue.sv ====
// small descriptor FIFO between the register frontend and the copy backend
// ready while not full, output valid the cycle after a write
module dma_xfer_queue
  import dma_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  dma_xfer_if.sink   in,
  dma_xfer_if.source out
);

  typedef logic [$clog2(QueueDepth)-1:0]   ptr_t;
  typedef logic [$clog2(QueueDepth+1)-1:0] count_t;

  addr_t  src_mem [QueueDepth];
  addr_t  dst_mem [QueueDepth];
  len_t   len_mem [QueueDepth];
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;
  logic   push;
  logic   pop;

  assign in.ready  = (count_q != count_t'(QueueDepth));
  assign out.valid = (count_q != '0);
  assign out.src   = src_mem[rd_ptr_q];
  assign out.dst   = dst_mem[rd_ptr_q];
  assign out.len   = len_mem[rd_ptr_q];

  assign push = in.valid && in.ready;
  assign pop  = out.valid && out.ready;

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      src_mem[wr_ptr_q] <= in.src;
      dst_mem[wr_ptr_q] <= in.dst;
      len_mem[wr_ptr_q] <= in.len;
    end
  end

  // pointers wrap at the last slot
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== tb_dma_properties.sv ====
// protocol assertions on the DMA ports, bound into dma_top
// config response timing, memory request hold and completion pulse width
module tb_dma_properties
  import dma_pkg::*;
(
  input logic  clk_i,
  input logic  reset_i,
  input logic  cfg_req_i,
  input logic  cfg_gnt_o,
  input logic  cfg_rvalid_o,
  input logic  mem_req_o,
  input logic  mem_we_o,
  input addr_t mem_addr_o,
  input data_t mem_wdata_o,
  input logic  mem_gnt_i,
  input logic  term_event_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // one response per granted access, one cycle later
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    (cfg_req_i && cfg_gnt_o) |=> cfg_rvalid_o)
    else $error("cfg_rvalid_o missing one cycle after a grant");

  rvalid_only_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    !(cfg_req_i && cfg_gnt_o) |=> !cfg_rvalid_o)
    else $error("cfg_rvalid_o without a granted access");

  // --------------------
  // memory request held until grant
  mem_hold_until_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
      && (!mem_we_o || $stable(mem_wdata_o))))
    else $error("memory request changed before grant");

  term_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    term_event_o |=> !term_event_o)
    else $error("term_event_o high for two cycles");

endmodule

bind dma_top tb_dma_properties tb_dma_properties_inst (.*);

// ==== tb_dma_top.sv ====
// testbench for the word-copy DMA that replays dma_stim.txt through the config port
// and checks every memory access against a model with random handshake delays
module tb_dma_top
  import dma_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam data_t       MemSalt   = 32'h5a3c_96e1;
  localparam int unsigned WaitLimit = 5000;

  logic      clk_i;
  logic      reset_i      = 1'b1;
  logic      cfg_req_i    = 1'b0;
  logic      cfg_we_i     = 1'b0;
  reg_addr_t cfg_addr_i   = '0;
  data_t     cfg_wdata_i  = '0;
  logic      cfg_gnt_o;
  logic      cfg_rvalid_o;
  data_t     cfg_rdata_o;
  logic      mem_req_o;
  logic      mem_we_o;
  addr_t     mem_addr_o;
  data_t     mem_wdata_o;
  logic      mem_gnt_i    = 1'b0;
  logic      mem_rvalid_i = 1'b0;
  data_t     mem_rdata_i  = '0;
  logic      term_event_o;
  logic      busy_o;

  data_t       mem [65536];
  addr_t       exp_rd_addr [$];
  addr_t       exp_wr_addr [$];
  data_t       exp_wr_data [$];
  int          seed          = 8;
  int unsigned gnt_wait      = 0;
  int unsigned rd_wait       = 0;
  logic        rd_pending    = 1'b0;
  data_t       rd_word       = '0;
  int unsigned term_count    = 0;
  int unsigned held_launches = 0;

  dma_top dma_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------
  // reporting and checks
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) fail_run($sformatf("error %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) fail_run($sformatf("error %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_id(input string name, input xfer_id_t exp, input xfer_id_t act);
    if (act !== exp) fail_run($sformatf("error %s: expected %0d actual %0d", name, exp, act));
  endtask

  function automatic int unsigned random_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  // one config access started right after a rising edge
  task automatic cfg_access(input logic we, input reg_addr_t addr, input data_t wdata,
                            output data_t rdata);
    int unsigned cycles;
    cfg_req_i   <= 1'b1;
    cfg_we_i    <= we;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= wdata;
    cycles = 0;
    @(posedge clk_i);
    while (!cfg_gnt_o) begin
      if (!we && addr == RegLaunch) held_launches++;
      cycles++;
      if (cycles > WaitLimit) fail_run("timeout: cfg_gnt_o never came");
      @(posedge clk_i);
    end
    cfg_req_i <= 1'b0;
    cycles = 0;
    @(posedge clk_i);
    while (!cfg_rvalid_o) begin
      cycles++;
      if (cycles > WaitLimit) fail_run("timeout: cfg_rvalid_o never came");
      @(posedge clk_i);
    end
    rdata = cfg_rdata_o;
  endtask

  // --------------------
  // memory model with one outstanding read
  always @(posedge clk_i) begin
    if (reset_i) begin
      mem_gnt_i    <= 1'b0;
      mem_rvalid_i <= 1'b0;
    end else begin
      mem_rvalid_i <= 1'b0;
      if (rd_pending) begin
        if (rd_wait == 0) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= rd_word;
          rd_pending = 1'b0;
        end else begin
          rd_wait--;
        end
      end
      if (mem_req_o && mem_gnt_i) begin
        if (mem_we_o) begin
          if (exp_wr_addr.size() == 0) fail_run("memory write outside any transfer");
          check_addr("write address", exp_wr_addr.pop_front(), mem_addr_o);
          check_data("write data", exp_wr_data.pop_front(), mem_wdata_o);
          mem[mem_addr_o] = mem_wdata_o;
        end else begin
          if (exp_rd_addr.size() == 0) fail_run("memory read outside any transfer");
          check_addr("read address", exp_rd_addr.pop_front(), mem_addr_o);
          rd_word    = mem[mem_addr_o];
          rd_wait    = random_delay();
          rd_pending = 1'b1;
        end
        mem_gnt_i <= 1'b0;
        gnt_wait = random_delay();
      end else if (mem_req_o) begin
        if (gnt_wait == 0) mem_gnt_i <= 1'b1;
        else gnt_wait--;
      end
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i && term_event_o) term_count++;
  end

  // --------------------
  // stimulus
  initial begin
    int          fd;
    string       line;
    addr_t       src;
    addr_t       dst;
    len_t        len;
    xfer_id_t    exp_id;
    data_t       rdata;
    int unsigned launches;
    int unsigned cycles;
    for (int a = 0; a < 65536; a++) mem[a] = data_t'(a) ^ MemSalt;
    launches = 0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    fd = $fopen("dma_stim.txt", "r");
    if (fd == 0) fail_run("cannot open stimulus file dma_stim.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if ($sscanf(line, "%h %h %h %h", src, dst, len, exp_id) == 4) begin
        // source words are still untouched here
        for (int k = 0; k < int'(len); k++) begin
          exp_rd_addr.push_back(src + addr_t'(k));
          exp_wr_addr.push_back(dst + addr_t'(k));
          exp_wr_data.push_back(mem[src + addr_t'(k)]);
        end
        cfg_access(1'b1, RegSrc, data_t'(src), rdata);
        cfg_access(1'b1, RegDst, data_t'(dst), rdata);
        cfg_access(1'b1, RegLen, data_t'(len), rdata);
        cfg_access(1'b0, RegLaunch, '0, rdata);
        launches++;
        check_id($sformatf("launch id of transfer %0d", launches), exp_id, rdata);
      end
    end
    $fclose(fd);

    cycles = 0;
    while (term_count < launches) begin
      cycles++;
      if (cycles > WaitLimit) fail_run("timeout: not every transfer raised term_event_o");
      @(posedge clk_i);
    end

    cfg_access(1'b0, RegDoneId, '0, rdata);
    check_id("done id after all transfers", exp_id, rdata);
    cfg_access(1'b0, RegStatus, '0, rdata);
    check_data("status register when idle", '0, rdata);
    if (busy_o !== 1'b0) fail_run("busy_o still high after all transfers completed");
    check_id("term_event_o pulse count", xfer_id_t'(launches), xfer_id_t'(term_count));
    if (held_launches == 0) fail_run("no launch was ever held off by a full queue");
    if (exp_rd_addr.size() != 0 || exp_wr_addr.size() != 0) begin
      fail_run("some expected memory accesses never happened");
    end
    $display("Everything OK");
    $finish;
  end

endmodule
